/* project.f */
+incdir+tests
src/cl_dark_pkg.sv
src/cl_line_unpack.sv
src/dark_coeff_queue.sv
src/dark_subtract.sv
src/cl_dark_top.sv
tests/tb_cl_dark.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, decide from the log
cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --timescale 1ns/1ps -f project.f \
  --top-module tb_cl_dark -Mdir "$obj" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj/sim_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
  echo "result: simulation passed"
  exit 0
else
  echo "result: simulation failed, see $log"
  exit 1
fi

/* src/cl_dark_pkg.sv */
package cl_dark_pkg;

  localparam int dn_width        = 12; // bits per pixel value
  localparam int col_width       = 12;
  localparam int n_lanes         = 4;  // pixel lanes per half
  localparam int n_ports         = 10; // camera link byte ports a..j
  localparam int queue_depth     = 8;
  localparam int queue_ptr_width = 3;

  // kind sits in the low two bits of a coefficient word
  typedef enum logic [1:0] {
    kind_invalid       = 2'd0,
    kind_pixel         = 2'd1,
    kind_row_reducer   = 2'd2,
    kind_patch_reducer = 2'd3
  } coeff_kind_e;

  typedef enum logic [2:0] {
    cl_phase0    = 3'd0,
    cl_phase1    = 3'd1,
    cl_phase2    = 3'd2,
    cl_interline = 3'd3,
    cl_error     = 3'd4 // final until reset
  } cl_state_e;

  // a..e carry the top half, f..j the bottom half
  typedef struct packed {
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
    logic [7:0] e;
    logic [7:0] f;
    logic [7:0] g;
    logic [7:0] h;
    logic [7:0] i;
    logic [7:0] j;
  } cl_ports_t;

  typedef struct packed {
    logic [n_lanes-1:0][dn_width-1:0] top;
    logic [n_lanes-1:0][dn_width-1:0] btm;
  } dark_set_t;

  typedef struct packed {
    dark_set_t   dark;
    coeff_kind_e kind;
  } coeff_word_t;

  typedef struct packed {
    logic [n_lanes-1:0][dn_width-1:0] top;
    logic [n_lanes-1:0][dn_width-1:0] btm;
    logic [col_width-1:0]             l_col; // column of lane 0
    logic [col_width-1:0]             r_col; // last column of the beat
    logic                             e012_valid;
    logic                             e3_valid;
  } raw_pixels_t;

  // same layout as raw_pixels_t, values are dark corrected
  typedef struct packed {
    logic [n_lanes-1:0][dn_width-1:0] top;
    logic [n_lanes-1:0][dn_width-1:0] btm;
    logic [col_width-1:0]             l_col;
    logic [col_width-1:0]             r_col;
    logic                             e012_valid;
    logic                             e3_valid;
  } corr_pixels_t;

endpackage

/* src/cl_dark_top.sv */
`timescale 1ns/1ps
module cl_dark_top (
  input  logic                      reset,   // pixel clock
  input  logic                      bus_clk, // async reset, active high
  input  logic                      cl_lval,
  input  cl_dark_pkg::cl_ports_t    cl_bytes,
  input  cl_dark_pkg::coeff_word_t  coeff_in,
  input  logic                      coeff_strobe,
  output cl_dark_pkg::corr_pixels_t pix_out,
  output logic                      pix_valid,
  output logic                      error,
  output logic                      coeff_full
);

  cl_dark_pkg::dark_set_t   coeff_head;
  cl_dark_pkg::raw_pixels_t raw;
  logic                     coeff_empty;
  logic                     coeff_pop;
  logic                     raw_valid;

  cl_line_unpack u_unpack (
    .reset       (reset),
    .bus_clk     (bus_clk),
    .cl_lval     (cl_lval),
    .cl_bytes    (cl_bytes),
    .coeff_empty (coeff_empty),
    .coeff_pop   (coeff_pop),
    .raw         (raw),
    .raw_valid   (raw_valid),
    .error       (error)
  );

  dark_coeff_queue u_queue (
    .reset        (reset),
    .bus_clk      (bus_clk),
    .coeff_in     (coeff_in),
    .coeff_strobe (coeff_strobe),
    .coeff_pop    (coeff_pop),
    .coeff_head   (coeff_head),
    .coeff_empty  (coeff_empty),
    .coeff_full   (coeff_full)
  );

  // second pipeline stage, two edges from beat to pix_valid
  dark_subtract u_subtract (
    .reset      (reset),
    .bus_clk    (bus_clk),
    .raw        (raw),
    .raw_valid  (raw_valid),
    .coeff_head (coeff_head),
    .pix_out    (pix_out),
    .pix_valid  (pix_valid)
  );

endmodule

/* src/cl_line_unpack.sv */
`timescale 1ns/1ps
module cl_line_unpack (
  input  logic                     reset,   // pixel clock
  input  logic                     bus_clk, // active-high async reset
  input  logic                     cl_lval,
  input  cl_dark_pkg::cl_ports_t   cl_bytes,
  input  logic                     coeff_empty,
  output logic                     coeff_pop,
  output cl_dark_pkg::raw_pixels_t raw,
  output logic                     raw_valid,
  output logic                     error
);

  cl_dark_pkg::cl_state_e state, state_nxt;
  logic [cl_dark_pkg::col_width-1:0] l_col_nxt;
  logic [cl_dark_pkg::col_width-1:0] r_col, r_col_nxt;
  logic accept;

  logic [cl_dark_pkg::n_ports-1:0][7:0] port_bytes; // a at the top index
  logic [7:0] keep_top, keep_btm;                   // remainder bits between phases
  logic [7:0] keep_top_nxt, keep_btm_nxt;
  logic [cl_dark_pkg::n_lanes-1:0][cl_dark_pkg::dn_width-1:0] dn_top_nxt, dn_btm_nxt;

  // unpacks one half with b[4] as its first byte
  function automatic void unpack_half(
    input  cl_dark_pkg::cl_state_e                   st,
    input  logic [cl_dark_pkg::n_ports/2-1:0][7:0]   b,
    input  logic [7:0]                               keep_in,
    output logic [cl_dark_pkg::n_lanes-1:0][cl_dark_pkg::dn_width-1:0] dn,
    output logic [7:0]                               keep_out
  );
    keep_out = keep_in;
    dn[3]    = '0; // lane 3 only filled in phase 2
    case (st)
      cl_dark_pkg::cl_phase1: begin
        dn[0]    = {keep_in[3:0], b[4]};
        dn[1]    = {b[3], b[2][7:4]};
        dn[2]    = {b[2][3:0], b[1]};
        keep_out = b[0]; // whole last byte carried
      end
      cl_dark_pkg::cl_phase2: begin
        dn[0] = {keep_in, b[4][7:4]};
        dn[1] = {b[4][3:0], b[3]};
        dn[2] = {b[2], b[1][7:4]};
        dn[3] = {b[1][3:0], b[0]};
      end
      default: begin // phase 0 and the first beat of a line
        dn[0]    = {b[4], b[3][7:4]};
        dn[1]    = {b[3][3:0], b[2]};
        dn[2]    = {b[1], b[0][7:4]};
        keep_out = {4'h0, b[0][3:0]};
      end
    endcase
  endfunction

  assign port_bytes = cl_bytes;

  assign accept    = (state != cl_dark_pkg::cl_error) && cl_lval && !coeff_empty;
  assign coeff_pop = accept; // head is consumed on the beat edge
  assign error     = (state == cl_dark_pkg::cl_error);

  assign l_col_nxt = r_col + cl_dark_pkg::col_width'(1); // first column of the beat

  always_comb begin
    unpack_half(state, port_bytes[cl_dark_pkg::n_ports-1 -: cl_dark_pkg::n_ports/2],
                keep_top, dn_top_nxt, keep_top_nxt);
    unpack_half(state, port_bytes[cl_dark_pkg::n_ports/2-1:0],
                keep_btm, dn_btm_nxt, keep_btm_nxt);
  end

  // state and column sequencing
  always_comb begin
    state_nxt = state;
    r_col_nxt = r_col;
    if (state != cl_dark_pkg::cl_error) begin
      if (!cl_lval) begin
        state_nxt = cl_dark_pkg::cl_interline;
        r_col_nxt = '1; // next line starts at column 0
      end else if (coeff_empty) begin
        state_nxt = cl_dark_pkg::cl_error; // beat without a dark value
      end else begin
        case (state)
          cl_dark_pkg::cl_phase1: begin
            state_nxt = cl_dark_pkg::cl_phase2;
            r_col_nxt = r_col + cl_dark_pkg::col_width'(3);
          end
          cl_dark_pkg::cl_phase2: begin
            state_nxt = cl_dark_pkg::cl_phase0;
            r_col_nxt = r_col + cl_dark_pkg::col_width'(4);
          end
          default: begin
            state_nxt = cl_dark_pkg::cl_phase1;
            r_col_nxt = r_col + cl_dark_pkg::col_width'(3);
          end
        endcase
      end
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      state     <= cl_dark_pkg::cl_interline;
      r_col     <= '0;
      raw_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      r_col     <= r_col_nxt;
      raw_valid <= accept;
    end
  end

  // beat payload and remainder buffers
  always_ff @(posedge reset) begin
    if (accept) begin
      raw.top        <= dn_top_nxt;
      raw.btm        <= dn_btm_nxt;
      raw.l_col      <= l_col_nxt;
      raw.r_col      <= r_col_nxt;
      raw.e012_valid <= (state_nxt != cl_dark_pkg::cl_interline);
      raw.e3_valid   <= (state_nxt == cl_dark_pkg::cl_phase0); // four-value beat
      keep_top       <= keep_top_nxt;
      keep_btm       <= keep_btm_nxt;
    end
  end

endmodule

/* src/dark_coeff_queue.sv */
`timescale 1ns/1ps
module dark_coeff_queue (
  input  logic                     reset,   // pixel clock
  input  logic                     bus_clk, // async reset, active high
  input  cl_dark_pkg::coeff_word_t coeff_in,
  input  logic                     coeff_strobe,
  input  logic                     coeff_pop,
  output cl_dark_pkg::dark_set_t   coeff_head,
  output logic                     coeff_empty,
  output logic                     coeff_full
);

  cl_dark_pkg::dark_set_t mem [cl_dark_pkg::queue_depth];

  logic [cl_dark_pkg::queue_ptr_width-1:0] wr_ptr, rd_ptr;
  logic [cl_dark_pkg::queue_ptr_width:0]   count; // one extra bit for full
  logic wr_en;

  // only pixel words are kept, everything else falls on the floor
  assign wr_en = coeff_strobe && !coeff_full
                 && (coeff_in.kind == cl_dark_pkg::kind_pixel);

  assign coeff_full  = (count == (cl_dark_pkg::queue_ptr_width + 1)'(cl_dark_pkg::queue_depth));
  assign coeff_empty = (count == '0);
  assign coeff_head  = mem[rd_ptr]; // fall-through head

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + cl_dark_pkg::queue_ptr_width'(1);
      if (coeff_pop)
        rd_ptr <= rd_ptr + cl_dark_pkg::queue_ptr_width'(1); // pointers wrap
      case ({wr_en, coeff_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge reset) begin
    if (wr_en)
      mem[wr_ptr] <= coeff_in.dark;
  end

endmodule

/* src/dark_subtract.sv */
`timescale 1ns/1ps
module dark_subtract (
  input  logic                      reset,   // pixel clock
  input  logic                      bus_clk, // async reset, active high
  input  cl_dark_pkg::raw_pixels_t  raw,
  input  logic                      raw_valid,
  input  cl_dark_pkg::dark_set_t    coeff_head,
  output cl_dark_pkg::corr_pixels_t pix_out,
  output logic                      pix_valid
);

  cl_dark_pkg::dark_set_t dark_q;

  // head sampled every edge
  // on a beat edge that is the word being popped, aligned with raw
  always_ff @(posedge reset) begin
    dark_q <= coeff_head;
  end

  always_ff @(posedge reset) begin
    if (raw_valid) begin
      for (int k = 0; k < cl_dark_pkg::n_lanes; k++) begin
        pix_out.top[k] <= raw.top[k] - dark_q.top[k]; // wraps mod 2^dn_width
        pix_out.btm[k] <= raw.btm[k] - dark_q.btm[k];
      end
      pix_out.l_col      <= raw.l_col;
      pix_out.r_col      <= raw.r_col;
      pix_out.e012_valid <= raw.e012_valid;
      pix_out.e3_valid   <= raw.e3_valid;
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk)
      pix_valid <= 1'b0;
    else
      pix_valid <= raw_valid;
  end

endmodule

/* tests/tb_cl_dark_vectors.svh */
`ifndef tb_cl_dark_vectors_svh
`define tb_cl_dark_vectors_svh

// one row per clock: stimulus, then error and coeff_full expected after that edge
typedef struct packed {
  logic                     lval;
  logic                     rnd_bytes; // bytes drawn from $random
  cl_dark_pkg::cl_ports_t   bytes;
  logic                     strobe;
  logic                     rnd_dark;  // dark values drawn from $random
  cl_dark_pkg::coeff_word_t coeff;
  logic                     exp_error;
  logic                     exp_full;
} vec_row_t;

localparam int exp_pulse_total = 15; // accepted beats of lines 1, 2 and 3

vec_row_t rows_q[$];
string    row_name_q[$];

task automatic add_row(input string name, input logic lval, input logic rnd_bytes,
                       input cl_dark_pkg::cl_ports_t bytes, input logic strobe,
                       input cl_dark_pkg::coeff_kind_e kind, input logic rnd_dark,
                       input cl_dark_pkg::dark_set_t dark, input logic exp_error,
                       input logic exp_full);
  vec_row_t row;
  row.lval       = lval;
  row.rnd_bytes  = rnd_bytes;
  row.bytes      = bytes;
  row.strobe     = strobe;
  row.rnd_dark   = rnd_dark;
  row.coeff.kind = kind;
  row.coeff.dark = dark;
  row.exp_error  = exp_error;
  row.exp_full   = exp_full;
  rows_q.push_back(row);
  row_name_q.push_back(name);
endtask

task automatic idle_row(input string name, input logic exp_error);
  add_row(name, 1'b0, 1'b0, '0, 1'b0, cl_dark_pkg::kind_invalid, 1'b0, '0, exp_error, 1'b0);
endtask

// coefficient write between lines
task automatic write_row(input string name, input cl_dark_pkg::coeff_kind_e kind,
                         input logic rnd_dark, input cl_dark_pkg::dark_set_t dark,
                         input logic exp_full);
  add_row(name, 1'b0, 1'b0, '0, 1'b1, kind, rnd_dark, dark, 1'b0, exp_full);
endtask

task automatic beat_row(input string name, input logic rnd_bytes,
                        input cl_dark_pkg::cl_ports_t bytes, input logic strobe,
                        input logic exp_error);
  add_row(name, 1'b1, rnd_bytes, bytes, strobe, cl_dark_pkg::kind_pixel, 1'b1, '0,
          exp_error, 1'b0);
endtask

task automatic build_table();
  repeat (3) idle_row("reset_idle", 1'b0);
  write_row("fill_wrap", cl_dark_pkg::kind_pixel, 1'b0, '1, 1'b0); // raw - 0xfff wraps
  repeat (5) write_row("fill_line1", cl_dark_pkg::kind_pixel, 1'b1, '0, 1'b0);
  beat_row("line1_ramp", 1'b0, 80'h0123_4567_89ab_cdef_fedc, 1'b0, 1'b0);
  beat_row("line1_rand", 1'b1, '0, 1'b0, 1'b0);
  beat_row("line1_ones", 1'b0, '1, 1'b0, 1'b0);
  beat_row("line1_ramp_again", 1'b0, 80'h0123_4567_89ab_cdef_fedc, 1'b0, 1'b0);
  repeat (2) beat_row("line1_rand", 1'b1, '0, 1'b0, 1'b0);
  repeat (2) idle_row("line_gap", 1'b0);
  write_row("drop_invalid", cl_dark_pkg::kind_invalid, 1'b1, '0, 1'b0);
  write_row("keep_zero", cl_dark_pkg::kind_pixel, 1'b0, '0, 1'b0);
  write_row("drop_row_reducer", cl_dark_pkg::kind_row_reducer, 1'b1, '0, 1'b0);
  repeat (2) write_row("keep_pixel", cl_dark_pkg::kind_pixel, 1'b1, '0, 1'b0);
  write_row("drop_patch_reducer", cl_dark_pkg::kind_patch_reducer, 1'b1, '0, 1'b0);
  repeat (4) write_row("keep_pixel", cl_dark_pkg::kind_pixel, 1'b1, '0, 1'b0);
  write_row("fill_to_full", cl_dark_pkg::kind_pixel, 1'b1, '0, 1'b1);
  write_row("drop_while_full", cl_dark_pkg::kind_pixel, 1'b0, '1, 1'b1);
  repeat (2) beat_row("line2_beat", 1'b1, '0, 1'b0, 1'b0);
  beat_row("line2_beat_write", 1'b1, '0, 1'b1, 1'b0); // pop and push together
  repeat (3) beat_row("line2_beat", 1'b1, '0, 1'b0, 1'b0);
  repeat (2) idle_row("line_gap", 1'b0);
  repeat (3) beat_row("line3_beat", 1'b1, '0, 1'b0, 1'b0);
  beat_row("empty_beat", 1'b1, '0, 1'b0, 1'b1);
  repeat (2) beat_row("beat_after_error_write", 1'b1, '0, 1'b1, 1'b1);
  repeat (2) beat_row("beat_after_error", 1'b1, '0, 1'b0, 1'b1);
  repeat (3) idle_row("drain", 1'b1);
endtask

`endif

/* tests/tb_cl_dark.sv */
`timescale 1ns/1ps
module tb_cl_dark;

  localparam int reset_cycles = 5;

  logic                      reset;   // clock
  logic                      bus_clk; // reset
  logic                      cl_lval;
  cl_dark_pkg::cl_ports_t    cl_bytes;
  cl_dark_pkg::coeff_word_t  coeff_in;
  logic                      coeff_strobe;
  cl_dark_pkg::corr_pixels_t pix_out;
  logic                      pix_valid;
  logic                      error;
  logic                      coeff_full;

  integer seed;
  int     errors;
  int     seen_pulses;
  int     edges; // rising edges since reset release

  // reference model state
  cl_dark_pkg::cl_state_e            m_state;
  logic [7:0]                        m_carry_top, m_carry_btm;
  logic [cl_dark_pkg::col_width-1:0] m_r_col;
  cl_dark_pkg::dark_set_t            m_queue[$];

  // expected outputs waiting for their pix_valid edge
  cl_dark_pkg::corr_pixels_t exp_pix_q[$];
  int                        exp_due_q[$];
  string                     exp_name_q[$];

  `include "tb_cl_dark_vectors.svh"

  cl_dark_top u_dut (
    .reset        (reset),
    .bus_clk      (bus_clk),
    .cl_lval      (cl_lval),
    .cl_bytes     (cl_bytes),
    .coeff_in     (coeff_in),
    .coeff_strobe (coeff_strobe),
    .pix_out      (pix_out),
    .pix_valid    (pix_valid),
    .error        (error),
    .coeff_full   (coeff_full)
  );

  initial begin
    reset = 1'b0;
    forever #2 reset = ~reset;
  end

  task automatic check_pixels(input string name, input cl_dark_pkg::corr_pixels_t exp_v,
                              input cl_dark_pkg::corr_pixels_t act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s: expected %h, actual %h", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s: expected %b, actual %b", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input integer exp_v, input integer act_v);
    if (act_v !== exp_v) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp_v, act_v);
      errors++;
    end
  endtask

  // a half is a 40 bit stream, carried bits from the last beat sit in front of it
  function automatic void unpack_stream(input logic [39:0] half, input logic [7:0] carry_in,
                                        input int carry_bits, input int n_vals,
                                        output logic [3:0][11:0] dn,
                                        output logic [7:0] carry_out);
    logic [47:0] s;
    int          left;
    s    = {carry_in, half};
    left = 40 + carry_bits - 12 * n_vals;
    dn   = '0;
    for (int k = 0; k < n_vals; k++)
      dn[k] = 12'(s >> (40 + carry_bits - 12 * (k + 1))); // values taken msb first
    carry_out = 8'(s & ((48'd1 << left) - 48'd1));
  endfunction

  // effect of the coming edge on the model, from the inputs now driven
  task automatic predict_edge(input string name);
    cl_dark_pkg::corr_pixels_t exp_v;
    cl_dark_pkg::dark_set_t    dark;
    cl_dark_pkg::cl_state_e    next;
    logic [3:0][11:0]          raw_top, raw_btm;
    logic [11:0]               step;
    int                        carry_bits, n_vals;
    bit                        had_room;
    had_room = (m_queue.size() < cl_dark_pkg::queue_depth);
    if (m_state != cl_dark_pkg::cl_error) begin
      if (!cl_lval) begin
        m_state = cl_dark_pkg::cl_interline;
        m_r_col = '1;
      end else if (m_queue.size() == 0) begin
        m_state = cl_dark_pkg::cl_error;
      end else begin
        case (m_state)
          cl_dark_pkg::cl_phase1: begin
            carry_bits = 4;
            n_vals     = 3;
            step       = 12'd3;
            next       = cl_dark_pkg::cl_phase2;
          end
          cl_dark_pkg::cl_phase2: begin
            carry_bits = 8;
            n_vals     = 4;
            step       = 12'd4;
            next       = cl_dark_pkg::cl_phase0;
          end
          default: begin
            carry_bits = 0;
            n_vals     = 3;
            step       = 12'd3;
            next       = cl_dark_pkg::cl_phase1;
          end
        endcase
        unpack_stream({cl_bytes.a, cl_bytes.b, cl_bytes.c, cl_bytes.d, cl_bytes.e},
                      m_carry_top, carry_bits, n_vals, raw_top, m_carry_top);
        unpack_stream({cl_bytes.f, cl_bytes.g, cl_bytes.h, cl_bytes.i, cl_bytes.j},
                      m_carry_btm, carry_bits, n_vals, raw_btm, m_carry_btm);
        dark = m_queue.pop_front();
        for (int k = 0; k < cl_dark_pkg::n_lanes; k++) begin
          exp_v.top[k] = raw_top[k] - dark.top[k];
          exp_v.btm[k] = raw_btm[k] - dark.btm[k];
        end
        exp_v.l_col      = m_r_col + 12'd1;
        m_r_col          = m_r_col + step;
        exp_v.r_col      = m_r_col;
        exp_v.e012_valid = (next != cl_dark_pkg::cl_interline);
        exp_v.e3_valid   = (next == cl_dark_pkg::cl_phase0);
        m_state          = next;
        exp_pix_q.push_back(exp_v);
        exp_due_q.push_back(edges + 2); // beat edge, then subtractor edge
        exp_name_q.push_back(name);
      end
    end
    if (coeff_strobe && coeff_in.kind == cl_dark_pkg::kind_pixel && had_room)
      m_queue.push_back(coeff_in.dark);
  endtask

  task automatic drive_row(input int r);
    vec_row_t    row;
    logic [95:0] rnd96;
    row          = rows_q[r];
    cl_lval      = row.lval;
    coeff_strobe = row.strobe;
    coeff_in     = row.coeff;
    cl_bytes     = row.bytes;
    if (row.rnd_bytes) begin
      rnd96    = {$random(seed), $random(seed), $random(seed)};
      cl_bytes = rnd96[79:0];
    end
    if (row.rnd_dark) begin
      rnd96         = {$random(seed), $random(seed), $random(seed)};
      coeff_in.dark = rnd96;
    end
  endtask

  task automatic check_outputs(input int r);
    if (pix_valid === 1'b1)
      seen_pulses++;
    if (exp_due_q.size() != 0 && exp_due_q[0] == edges) begin
      if (pix_valid !== 1'b1) begin
        $display("ERROR: no pix_valid pulse for the beat of %s at edge %0d",
                 exp_name_q[0], edges);
        errors++;
      end else begin
        check_pixels(exp_name_q[0], exp_pix_q[0], pix_out);
      end
      void'(exp_pix_q.pop_front());
      void'(exp_due_q.pop_front());
      void'(exp_name_q.pop_front());
    end else if (pix_valid !== 1'b0) begin
      $display("ERROR: pix_valid pulse at edge %0d with no beat behind it", edges);
      errors++;
    end
    check_flag({row_name_q[r], " error"}, rows_q[r].exp_error, error);
    check_flag({row_name_q[r], " coeff_full"}, rows_q[r].exp_full, coeff_full);
  endtask

  function automatic int run_limit();
    return rows_q.size() + reset_cycles + 20;
  endfunction

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < run_limit()) begin
      @(posedge reset);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", cycles);
    $display("errors: %0d", errors + 1);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    seed         = 49;
    errors       = 0;
    seen_pulses  = 0;
    edges        = 0;
    bus_clk      = 1'b1;
    cl_lval      = 1'b0;
    cl_bytes     = '0;
    coeff_in     = '0;
    coeff_strobe = 1'b0;
    m_state      = cl_dark_pkg::cl_interline;
    m_r_col      = '0;
    m_carry_top  = '0;
    m_carry_btm  = '0;
    build_table();

    repeat (reset_cycles) @(posedge reset);
    #1;
    check_flag("reset pix_valid", 1'b0, pix_valid);
    check_flag("reset error", 1'b0, error);
    check_flag("reset coeff_full", 1'b0, coeff_full);
    bus_clk = 1'b0;

    for (int r = 0; r < rows_q.size(); r++) begin
      drive_row(r); // 1 ns after the edge
      predict_edge(row_name_q[r]);
      @(posedge reset);
      #1;
      edges++;
      check_outputs(r);
    end

    if (exp_due_q.size() != 0) begin
      $display("ERROR: %0d corrected beats never came out", exp_due_q.size());
      errors++;
    end
    check_count("pix_valid pulses", exp_pulse_total, seen_pulses);

    $display("errors: %0d, pix_valid pulses: %0d", errors, seen_pulses);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
